//--- build.f
+incdir+hw
hw/softmax_pkg.sv
hw/score_beat_if.sv
hw/row_dispatcher.sv
hw/row_max_lane.sv
hw/max_result_collector.sv
hw/softmax_max_top.sv
verification/tb_softmax_max.sv

//--- hw/max_result_collector.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module max_result_collector (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [`NUM_LANES-1:0]       lane_valid,
  input  softmax_pkg::score_t         lane_max [`NUM_LANES],
  output logic [`NUM_LANES-1:0]       lane_ready,
  output logic                        result_valid,
  output softmax_pkg::score_t         result_max,
  input  logic                        result_ready
);
  import softmax_pkg::*;

  lane_idx_t rd_ptr;   // lane holding the oldest row
  logic      out_free; // output register empty or leaving this cycle
  logic      take;

  assign out_free = !result_valid || result_ready;
  assign take     = lane_valid[rd_ptr] && out_free;

  // only the pointed lane may hand over
  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      lane_ready[i] = out_free && (rd_ptr == lane_idx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      rd_ptr       <= '0;
    end else if (take) begin
      result_valid <= 1'b1;
      rd_ptr       <= rd_ptr + lane_idx_t'(1);
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (take) begin
      result_max <= lane_max[rd_ptr];
    end
  end

  a_result_stable: assert property (
    @(posedge clk) disable iff (reset)
    (result_valid && !result_ready) |=> (result_valid && $stable(result_max))
  );

endmodule

//--- hw/row_dispatcher.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module row_dispatcher (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      score_valid,
  input  softmax_pkg::score_beat_t  score_data,
  output logic                      score_ready,
  score_beat_if.source              lanes [`NUM_LANES]
);
  import softmax_pkg::*;

  beat_cnt_t              beat_cnt; // position of the next beat in its row
  lane_idx_t              lane_ptr; // lane that owns the current row
  logic                   row_last;
  logic                   score_fire;
  logic [`NUM_LANES-1:0]  lane_ready_vec;

  assign row_last   = (beat_cnt == beat_cnt_t'(`ROW_BEATS - 1));
  assign score_ready = lane_ready_vec[lane_ptr];
  assign score_fire  = score_valid && score_ready;

  // fan out to the lanes, only the selected one sees valid
  genvar i;
  generate
    for (i = 0; i < `NUM_LANES; i++) begin : g_lane_route
      assign lanes[i].valid  = score_valid && (lane_ptr == lane_idx_t'(i));
      assign lanes[i].scores = score_data;
      assign lanes[i].last   = row_last;
      assign lane_ready_vec[i] = lanes[i].ready;
    end
  endgenerate

  // beat counter and round-robin pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
      lane_ptr <= '0;
    end else if (score_fire) begin
      if (row_last) begin
        beat_cnt <= '0;
        lane_ptr <= lane_ptr + lane_idx_t'(1); // next row goes to next lane
      end else begin
        beat_cnt <= beat_cnt + beat_cnt_t'(1);
      end
    end
  end

  // a stalled beat stays on the input until it transfers
  a_input_held: assert property (
    @(posedge clk) disable iff (reset)
    (score_valid && !score_ready) |=> (score_valid && $stable(score_data))
  );

endmodule

//--- hw/row_max_lane.sv
`timescale 1ns/1ps

module row_max_lane (
  input  logic                 clk,
  input  logic                 reset,
  score_beat_if.sink           beat_in,
  output logic                 res_valid,
  output softmax_pkg::score_t  res_max,
  input  logic                 res_ready
);
  import softmax_pkg::*;

  lane_state_t state;
  logic        accept;
  logic        handoff;
  logic        mid_row;    // some beats of the current row already taken
  logic        row_closed; // last beat taken, waiting for handoff

  // stage 1, pair maxima
  logic   s1_valid;
  logic   s1_first;
  logic   s1_last;
  score_t s1_max_lo;
  score_t s1_max_hi;

  // stage 2, beat maximum
  logic   s2_valid;
  logic   s2_first;
  logic   s2_last;
  score_t s2_max;

  // stage 3, running maximum
  score_t acc;

  assign beat_in.ready = !row_closed;
  assign accept        = beat_in.valid && beat_in.ready;
  assign handoff       = res_valid && res_ready;
  assign res_valid     = (state == LANE_HOLD);
  assign res_max       = acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      mid_row    <= 1'b0;
      row_closed <= 1'b0;
    end else begin
      if (accept) begin
        mid_row <= !beat_in.last;
      end
      if (accept && beat_in.last) begin
        row_closed <= 1'b1;
      end else if (handoff) begin
        row_closed <= 1'b0;
      end
    end
  end

  // control flags of the pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= accept;
      s2_valid <= s1_valid;
    end
  end

  // datapath, flags travel with the data
  always_ff @(posedge clk) begin
    s1_first  <= !mid_row;
    s1_last   <= beat_in.last;
    s1_max_lo <= score_max(beat_in.scores[0], beat_in.scores[1]);
    s1_max_hi <= score_max(beat_in.scores[2], beat_in.scores[3]);
    s2_first  <= s1_first;
    s2_last   <= s1_last;
    s2_max    <= score_max(s1_max_lo, s1_max_hi);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (s2_valid) begin
      acc <= s2_first ? s2_max : score_max(acc, s2_max); // first beat loads
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= LANE_COLLECT;
    end else begin
      case (state)
        LANE_COLLECT: if (s2_valid && s2_last) state <= LANE_HOLD;
        LANE_HOLD:    if (handoff) state <= LANE_COLLECT;
        default:      state <= LANE_COLLECT;
      endcase
    end
  end

  a_no_accept_in_hold: assert property (
    @(posedge clk) disable iff (reset)
    accept |-> (state != LANE_HOLD)
  );

  a_res_stable: assert property (
    @(posedge clk) disable iff (reset)
    (res_valid && !res_ready) |=> $stable(res_max)
  );

endmodule

//--- hw/score_beat_if.sv
`timescale 1ns/1ps

interface score_beat_if;
  import softmax_pkg::*;

  logic        valid;
  score_beat_t scores;
  logic        last; // eighth beat of a row
  logic        ready;

  modport source (
    output valid,
    output scores,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  scores,
    input  last,
    output ready
  );

endinterface

//--- hw/softmax_cfg.svh
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// score format, signed fixed point
`define SCORE_WIDTH 16

// beat and row geometry
`define SCORES_PER_BEAT 4
`define ROW_LENGTH 32 // words in the sentence
`define ROW_BEATS (`ROW_LENGTH / `SCORES_PER_BEAT)

// lane replication
`define NUM_LANES 4
`define LANE_IDX_WIDTH 2 // log2 of NUM_LANES

// counts 0 .. ROW_BEATS-1
`define BEAT_CNT_WIDTH 3

`endif

//--- hw/softmax_max_top.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module softmax_max_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      score_valid,
  input  softmax_pkg::score_beat_t  score_data,
  output logic                      score_ready,
  output logic                      result_valid,
  output softmax_pkg::score_t       result_max,
  input  logic                      result_ready
);
  import softmax_pkg::*;

  // dispatcher to lane beat channels
  score_beat_if lane_bus [`NUM_LANES] ();

  // lane to collector result channels
  logic [`NUM_LANES-1:0] lane_valid;
  score_t                lane_max [`NUM_LANES];
  logic [`NUM_LANES-1:0] lane_ready;

  row_dispatcher u_row_dispatcher (
    .clk         (clk),
    .reset       (reset),
    .score_valid (score_valid),
    .score_data  (score_data),
    .score_ready (score_ready),
    .lanes       (lane_bus)
  );

  genvar g;
  generate
    for (g = 0; g < `NUM_LANES; g++) begin : g_lane
      row_max_lane u_row_max_lane (
        .clk       (clk),
        .reset     (reset),
        .beat_in   (lane_bus[g]),
        .res_valid (lane_valid[g]),
        .res_max   (lane_max[g]),
        .res_ready (lane_ready[g])
      );
    end
  endgenerate

  max_result_collector u_max_result_collector (
    .clk          (clk),
    .reset        (reset),
    .lane_valid   (lane_valid),
    .lane_max     (lane_max),
    .lane_ready   (lane_ready),
    .result_valid (result_valid),
    .result_max   (result_max),
    .result_ready (result_ready)
  );

endmodule

//--- hw/softmax_pkg.sv
`include "softmax_cfg.svh"

package softmax_pkg;

  // one attention score
  typedef logic signed [`SCORE_WIDTH-1:0] score_t;

  // one input beat, score 0 in the low bits
  typedef score_t [`SCORES_PER_BEAT-1:0] score_beat_t;

  typedef logic [`LANE_IDX_WIDTH-1:0] lane_idx_t;

  typedef logic [`BEAT_CNT_WIDTH-1:0] beat_cnt_t;

  // result holding in a max lane
  typedef enum logic [0:0] {
    LANE_COLLECT,
    LANE_HOLD
  } lane_state_t;

  // larger of two scores, keeps a on a tie
  function automatic score_t score_max(input score_t a, input score_t b);
    if (a >= b) begin
      return a;
    end
    return b;
  endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module tb_softmax_max -o sim_tb_softmax_max \
  && ./obj_dir/sim_tb_softmax_max | tee /dev/stderr | grep -q "Finished with no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verification/tb_softmax_max.sv
`timescale 1ns/1ps
`include "softmax_cfg.svh"

module tb_softmax_max;
  import softmax_pkg::*;

  // 17 rows of 8 beats, with room for stalls, times eight
  localparam int MAX_CYCLES = 4000;

  logic        clk;
  logic        reset;
  logic        score_valid;
  score_beat_t score_data;
  logic        score_ready;
  logic        result_valid;
  score_t      result_max;
  logic        result_ready;

  score_t      row_buf [`ROW_LENGTH];
  score_t      exp_q [$];          // expected maxima, oldest row first
  logic [15:0] data_lfsr;
  logic [15:0] ready_lfsr;
  logic        bp_mode;            // random result_ready when set
  logic        held_valid;
  score_t      held_max;
  int          cycle_cnt;
  int          stall_cnt;          // beats held back by score_ready

  softmax_max_top u_softmax_max_top (
    .clk          (clk),
    .reset        (reset),
    .score_valid  (score_valid),
    .score_data   (score_data),
    .score_ready  (score_ready),
    .result_valid (result_valid),
    .result_max   (result_max),
    .result_ready (result_ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // signed maximum over the row, straight from the definition
  function automatic score_t row_reference();
    score_t m;
    m = row_buf[0];
    for (int i = 1; i < `ROW_LENGTH; i++) begin
      if (row_buf[i] > m) m = row_buf[i];
    end
    return m;
  endfunction

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_score(input string name, input score_t exp, input score_t act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[ERROR] %0t ns %s expected %0d got %0d",
                                $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_failure($sformatf("[ERROR] %0t ns %s expected %b got %b",
                                $time, name, exp, act));
    end
  endtask

  task automatic fill_random_row();
    logic [15:0] v;
    for (int i = 0; i < `ROW_LENGTH; i++) begin
      v = '0;
      for (int k = 0; k < 16; k++) begin
        v = {v[14:0], data_lfsr[0]}; // one step per bit taken
        data_lfsr = lfsr_step(data_lfsr);
      end
      row_buf[i] = score_t'(v);
    end
  endtask

  // push the expected max, then drive the row beat by beat
  task automatic send_row();
    score_beat_t beat;
    logic        ok;
    exp_q.push_back(row_reference());
    for (int b = 0; b < `ROW_BEATS; b++) begin
      for (int j = 0; j < `SCORES_PER_BEAT; j++) begin
        beat[j] = row_buf[b * `SCORES_PER_BEAT + j];
      end
      score_valid = 1'b1;
      score_data  = beat;
      do begin
        @(negedge clk);
        ok = score_ready; // transfer happens on the coming edge
        if (!ok) begin
          stall_cnt++;
        end
        @(posedge clk);
        #1;
      end while (!ok);
    end
    score_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_flag("result_valid", 1'b0, result_valid);
    check_flag("score_ready", 1'b1, score_ready);
    @(posedge clk);
    #1;
  endtask

  task automatic test_single_row_mixed();
    for (int i = 0; i < `ROW_LENGTH; i++) begin
      row_buf[i] = (i % 2 == 1) ? score_t'(-(i * 37)) : score_t'(i * 29);
    end
    row_buf[7] = score_t'(1234); // last lane of beat 1
    send_row();
    wait_drained();
  endtask

  task automatic test_all_negative();
    for (int i = 0; i < `ROW_LENGTH; i++) begin
      row_buf[i] = score_t'(-1000 - i * 50);
    end
    row_buf[5]  = score_t'(-32768);
    row_buf[20] = score_t'(-3);
    send_row();
    for (int i = 0; i < `ROW_LENGTH; i++) begin
      row_buf[i] = score_t'(-77); // all equal
    end
    send_row();
    wait_drained();
  endtask

  task automatic test_lanes_in_order();
    for (int r = 0; r < 6; r++) begin
      fill_random_row();
      send_row();
    end
    wait_drained();
  endtask

  task automatic test_backpressure();
    @(negedge clk);
    stall_cnt = 0;
    bp_mode   = 1'b1;
    @(posedge clk);
    #1;
    for (int r = 0; r < 8; r++) begin
      fill_random_row();
      send_row();
    end
    wait_drained();
    @(negedge clk);
    bp_mode = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // result_ready driver
  initial begin
    result_ready = 1'b0;
    ready_lfsr   = 16'd78;
    forever begin
      @(posedge clk);
      #1;
      if (bp_mode && stall_cnt == 0) begin
        result_ready = 1'b0; // lanes fill up until the input stalls
      end else if (bp_mode) begin
        result_ready = ready_lfsr[0];
        ready_lfsr   = lfsr_step(ready_lfsr);
      end else begin
        result_ready = 1'b1;
      end
    end
  end

  // result monitor, samples mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (held_valid) begin
        check_flag("result_valid", 1'b1, result_valid);
        check_score("result_max", held_max, result_max);
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          stop_on_failure("a result came out with no row outstanding");
        end else begin
          check_score("result_max", exp_q.pop_front(), result_max);
        end
      end
      held_valid = result_valid && !result_ready;
      held_max   = result_max;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      stop_on_failure("timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    reset       = 1'b1;
    score_valid = 1'b0;
    score_data  = '0;
    bp_mode     = 1'b0;
    held_valid  = 1'b0;
    held_max    = '0;
    cycle_cnt   = 0;
    stall_cnt   = 0;
    data_lfsr   = 16'd78;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_state();
    test_single_row_mixed();
    test_all_negative();
    test_lanes_in_order();
    test_backpressure();

    $display("Finished with no errors");
    $finish;
  end

endmodule
